/* camera_previewer.f */
common/previewer_pkg.sv
host_link/word_concatenator.sv
host_link/constants_controller.sv
frame_output/frame_serializer.sv
logic/camera_timing.sv
logic/camera_previewer.sv
bench/clock_gen.sv
bench/camera_previewer_assert.sv
bench/tb_camera_previewer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, then scan the log for the result
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_camera_previewer -f camera_previewer.f -o tb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test completed successfully" sim.log \
    || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* bench/tb_camera_previewer.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_camera_previewer;
    import previewer_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;
    localparam logic [31:0] LFSR_SEED = 32'hba83_3c1d;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk_pll;
    logic        sys_reset;
    logic [7:0]  host_byte;
    logic        host_byte_valid;
    pixel_pair_t pixel;
    logic        pixel_valid;
    logic        sof;
    logic        stall;
    logic [15:0] fifo_space;
    logic [7:0]  out_byte;
    logic        out_byte_valid;
    matrix_set_t matrices;
    roi_corner_t pre_roi;
    roi_corner_t post_roi;
    logic        mclk;
    logic        shutter_trig;

    logic [31:0] lfsr_state;
    int          cycle_cnt = 0;
    int          error_cnt = 0;
    logic [7:0]  got_q[$];
    logic [7:0]  exp_q[$];
    int          exp_coeff[NUM_CAMERAS*MATRIX_COEFFS];
    roi_corner_t exp_pre;
    roi_corner_t exp_post;

    clock_gen u_clock_gen (
        .clk_pll  (clk_pll),
        .sys_reset(sys_reset)
    );

    camera_previewer UUT (
        .clk_pll          (clk_pll),
        .sys_reset        (sys_reset),
        .host_byte_i      (host_byte),
        .host_byte_valid_i(host_byte_valid),
        .pixel_i          (pixel),
        .pixel_valid_i    (pixel_valid),
        .sof_i            (sof),
        .stall_o          (stall),
        .fifo_space_i     (fifo_space),
        .out_byte_o       (out_byte),
        .out_byte_valid_o (out_byte_valid),
        .matrices_o       (matrices),
        .pre_roi_o        (pre_roi),
        .post_roi_o       (post_roi),
        .mclk_o           (mclk),
        .shutter_trig_o   (shutter_trig)
    );

    bind camera_timing camera_previewer_assert u_timing_assert (
        .clk_pll(clk_pll), .sys_reset(sys_reset), .mclk_i(mclk_o),
        .shutter_trig_i(shutter_trig_o), .out_byte_valid_i(1'b0)
    );

    bind frame_serializer camera_previewer_assert u_output_assert (
        .clk_pll(clk_pll), .sys_reset(sys_reset), .mclk_i(1'b0),
        .shutter_trig_i(1'b0), .out_byte_valid_i(out_byte_valid_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] value);
        value = '0;
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            error_cnt++;
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // six bytes, address first, most significant byte first
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] word;
        word = {addr, data};
        for (int i = CMD_BYTES - 1; i >= 0; i--) begin
            @(negedge clk_pll);
            host_byte       = word[8*i +: 8];
            host_byte_valid = 1'b1;
        end
        @(negedge clk_pll);
        host_byte_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        send_cmd(addr, data);
        @(negedge clk_pll);
    endtask

    task automatic check_regs();
        for (int c = 0; c < NUM_CAMERAS; c++) begin
            for (int k = 0; k < MATRIX_COEFFS; k++) begin
                check_value($sformatf("matrices_o[%0d][%0d]", c, k), matrices[c][k],
                            exp_coeff[MATRIX_COEFFS*c + k]);
            end
        end
        check_value("pre_roi_o", pre_roi, exp_pre);
        check_value("post_roi_o", post_roi, exp_post);
    endtask

    task automatic send_pixel(input logic [7:0] ch0, input logic [7:0] ch1,
                              input logic first);
        @(negedge clk_pll);
        pixel.ch0   = ch0;
        pixel.ch1   = ch1;
        sof         = first;
        pixel_valid = 1'b1;
        // held until the serializer takes it
        while (stall) begin
            @(negedge clk_pll);
        end
    endtask

    task automatic send_frame(input int n_pixels);
        logic [63:0] magic;
        logic [7:0]  ch0;
        logic [7:0]  ch1;
        magic = "BIVFRAME";
        for (int i = 7; i >= 0; i--) begin
            exp_q.push_back(magic[8*i +: 8]);
        end
        for (int p = 0; p < n_pixels; p++) begin
            rand_byte(ch0);
            rand_byte(ch1);
            exp_q.push_back(ch0);
            exp_q.push_back(ch1);
            send_pixel(ch0, ch1, p == 0);
        end
        @(negedge clk_pll);
        pixel_valid = 1'b0;
        sof         = 1'b0;
    endtask

    task automatic start_capture();
        @(posedge clk_pll);
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic verify_frame();
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk_pll);
        end
        // a few idle cycles to catch stray bytes
        repeat (4) @(posedge clk_pll);
        check_value("out_byte_o count", got_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_value($sformatf("out_byte_o[%0d]", i), got_q[i], exp_q[i]);
        end
    endtask

    task automatic count_to_pulse(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_pll);
            cycles++;
        end while (!shutter_trig);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset_defaults();
        // identity matrices, 1.0 is 256 on coefficients 0, 4 and 8
        for (int i = 0; i < NUM_CAMERAS*MATRIX_COEFFS; i++) begin
            exp_coeff[i] = (i % 9 == 0 || i % 9 == 4 || i % 9 == 8) ? 256 : 0;
        end
        exp_pre  = {16'd0, 16'd64};
        exp_post = {16'd0, 16'd56};
        check_regs();
        check_value("out_byte_valid_o", out_byte_valid, 1'b0);
        check_value("shutter_trig_o", shutter_trig, 1'b0);
    endtask

    task automatic test_command_writes();
        // camera 1, coefficient 4; old value still there one cycle after the last byte
        send_cmd(16'd13, 32'd291);
        check_regs();
        exp_coeff[13] = 291;
        @(negedge clk_pll);
        check_regs();
        // negative, with junk above the coefficient field
        write_reg(16'd2, {13'h1abc, 19'h7fed4});
        exp_coeff[2] = -300;
        check_regs();
        send_cmd(ADDR_PRE_ROI, {16'd12, 16'd80});
        check_regs();
        exp_pre = {16'd12, 16'd80};
        @(negedge clk_pll);
        check_regs();
        write_reg(ADDR_POST_ROI, {16'd7, 16'd33});
        exp_post = {16'd7, 16'd33};
        check_regs();
        // unmapped addresses
        write_reg(16'h0012, 32'hffff_ffff);
        check_regs();
        write_reg(16'h0300, 32'hffff_ffff);
        check_regs();
    endtask

    task automatic test_frame_format();
        start_capture();
        send_frame(6);
        verify_frame();
    endtask

    task automatic test_back_pressure();
        start_capture();
        fork
            send_frame(10);
            begin
                repeat (14) @(negedge clk_pll);
                fifo_space = 16'(SPACE_THRESHOLD);
                // one byte may still slip out while has_space catches up
                repeat (2) @(negedge clk_pll);
                repeat (12) begin
                    check_value("out_byte_valid_o", out_byte_valid, 1'b0);
                    check_value("stall_o", stall, 1'b1);
                    @(negedge clk_pll);
                end
                fifo_space = 16'd1024;
            end
        join
        verify_frame();
    endtask

    task automatic test_shutter();
        int gap;
        repeat (SHUTTER_PERIOD + SHUTTER_PERIOD / 2) begin
            @(negedge clk_pll);
            check_value("shutter_trig_o", shutter_trig, 1'b0);
        end
        send_cmd(ADDR_SHUTTER_EN, 32'd1);
        // enable lands one cycle later, then a full period
        count_to_pulse(gap);
        check_value("shutter_trig_o first delay", gap, SHUTTER_PERIOD + 1);
        repeat (2) begin
            count_to_pulse(gap);
            check_value("shutter_trig_o period", gap, SHUTTER_PERIOD);
        end
    endtask

    task automatic test_mclk();
        logic samples[16];
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_pll);
            samples[i] = mclk;
        end
        for (int i = 0; i < 12; i++) begin
            check_value("mclk_o half period", samples[i+2], !samples[i]);
            check_value("mclk_o period", samples[i+4], samples[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // byte capture and run limit
    always @(negedge clk_pll) begin
        if (out_byte_valid) begin
            got_q.push_back(out_byte);
        end
    end

    always @(posedge clk_pll) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "run limit reached");
        end
    end

    initial begin
        host_byte       = '0;
        host_byte_valid = 1'b0;
        pixel           = '0;
        pixel_valid     = 1'b0;
        sof             = 1'b0;
        fifo_space      = 16'd1024;
        lfsr_state      = LFSR_SEED;
        @(negedge sys_reset);
        @(negedge clk_pll);
        test_reset_defaults();
        test_command_writes();
        test_frame_format();
        test_back_pressure();
        test_shutter();
        test_mclk();
        if (error_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/camera_previewer_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module camera_previewer_assert (
    input wire logic clk_pll,
    input wire logic sys_reset,
    input wire logic mclk_i,
    input wire logic shutter_trig_i,
    input wire logic out_byte_valid_i
);

    // shutter release is a single-cycle pulse
    a_trig_single: assert property (
        @(posedge clk_pll) disable iff (sys_reset)
        shutter_trig_i |=> !shutter_trig_i
    ) else $error("shutter trigger high for two cycles in a row");

    // master clock, two cycles high then two cycles low
    a_mclk_high: assert property (
        @(posedge clk_pll) disable iff (sys_reset)
        $rose(mclk_i) |=> mclk_i ##1 !mclk_i
    ) else $error("mclk high phase is not two cycles");

    a_mclk_low: assert property (
        @(posedge clk_pll) disable iff (sys_reset)
        $fell(mclk_i) |=> !mclk_i ##1 mclk_i
    ) else $error("mclk low phase is not two cycles");

    // nothing leaves the serializer right after reset
    a_out_quiet: assert property (
        @(posedge clk_pll)
        $fell(sys_reset) |=> !out_byte_valid_i
    ) else $error("output byte strobe high in the first cycle after reset");

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clk_pll,
    output logic sys_reset
);
    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_pll = 1'b0;
        forever #HALF_PERIOD clk_pll = ~clk_pll;
    end

    // released on a falling edge, clear of the sampling edge
    initial begin
        sys_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_pll);
        @(negedge clk_pll);
        sys_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/camera_previewer.sv */
`timescale 1ns/1ns
`default_nettype none

module camera_previewer (
    input  wire logic                       clk_pll,
    input  wire logic                       sys_reset,
    input  wire logic [7:0]                 host_byte_i,
    input  wire logic                       host_byte_valid_i,
    input  wire previewer_pkg::pixel_pair_t pixel_i,
    input  wire logic                       pixel_valid_i,
    input  wire logic                       sof_i,
    output logic                            stall_o,
    input  wire logic [15:0]                fifo_space_i,
    output logic [7:0]                      out_byte_o,
    output logic                            out_byte_valid_o,
    output previewer_pkg::matrix_set_t      matrices_o,
    output previewer_pkg::roi_corner_t      pre_roi_o,
    output previewer_pkg::roi_corner_t      post_roi_o,
    output logic                            mclk_o,
    output logic                            shutter_trig_o
);
    import previewer_pkg::*;

    command_t cmd;
    logic     cmd_valid;
    logic     shutter_en;

    ////////////////////////////////////////////////////////////////////////////
    // host command path
    word_concatenator u_word_concatenator (
        .clk_pll     (clk_pll),
        .sys_reset   (sys_reset),
        .byte_i      (host_byte_i),
        .byte_valid_i(host_byte_valid_i),
        .cmd_o       (cmd),
        .cmd_valid_o (cmd_valid)
    );

    constants_controller u_constants_controller (
        .clk_pll     (clk_pll),
        .sys_reset   (sys_reset),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .matrices_o  (matrices_o),
        .pre_roi_o   (pre_roi_o),
        .post_roi_o  (post_roi_o),
        .shutter_en_o(shutter_en)
    );

    ////////////////////////////////////////////////////////////////////////////
    // camera timing and frame output
    camera_timing u_camera_timing (
        .clk_pll       (clk_pll),
        .sys_reset     (sys_reset),
        .shutter_en_i  (shutter_en),
        .mclk_o        (mclk_o),
        .shutter_trig_o(shutter_trig_o)
    );

    frame_serializer u_frame_serializer (
        .clk_pll         (clk_pll),
        .sys_reset       (sys_reset),
        .pixel_i         (pixel_i),
        .pixel_valid_i   (pixel_valid_i),
        .sof_i           (sof_i),
        .stall_o         (stall_o),
        .fifo_space_i    (fifo_space_i),
        .out_byte_o      (out_byte_o),
        .out_byte_valid_o(out_byte_valid_o)
    );

endmodule

`default_nettype wire

/* logic/camera_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module camera_timing (
    input  wire logic clk_pll,
    input  wire logic sys_reset,
    input  wire logic shutter_en_i,
    output logic      mclk_o,
    output logic      shutter_trig_o
);
    import previewer_pkg::*;

    logic [MCLK_DIV_BITS-1:0]    div_cnt;
    logic [SHUTTER_CNT_BITS-1:0] shutter_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // master clock, core clock divided by four
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // top bit of the divider, only ever drives a pin
    assign mclk_o = div_cnt[MCLK_DIV_BITS-1];

    ////////////////////////////////////////////////////////////////////////////
    // shutter release pulse
    always_ff @(posedge clk_pll) begin
        if (sys_reset || !shutter_en_i) begin
            // held clear so the first pulse is a full period out
            shutter_cnt    <= '0;
            shutter_trig_o <= 1'b0;
        end else if (shutter_cnt == SHUTTER_CNT_BITS'(SHUTTER_PERIOD - 1)) begin
            shutter_cnt    <= '0;
            shutter_trig_o <= 1'b1;
        end else begin
            shutter_cnt    <= shutter_cnt + 1'b1;
            shutter_trig_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* frame_output/frame_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_serializer (
    input  wire logic                       clk_pll,
    input  wire logic                       sys_reset,
    input  wire previewer_pkg::pixel_pair_t pixel_i,
    input  wire logic                       pixel_valid_i,
    input  wire logic                       sof_i,
    output logic                            stall_o,
    input  wire logic [15:0]                fifo_space_i,
    output logic [7:0]                      out_byte_o,
    output logic                            out_byte_valid_o
);
    import previewer_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        CH0,
        CH1
    } state_t;

    state_t                  state;
    logic [HDR_IDX_BITS-1:0] byte_idx;
    pixel_pair_t             pixel_q;
    logic                    has_space;
    logic                    accept;
    logic                    emit;
    logic [7:0]              header_byte;
    logic [7:0]              next_byte;

    ////////////////////////////////////////////////////////////////////////////
    // host fifo back-pressure, one cycle late
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            has_space <= 1'b0;
        end else begin
            has_space <= fifo_space_i > 16'(SPACE_THRESHOLD);
        end
    end

    // one pixel in flight at a time
    assign stall_o = (state != IDLE) || !has_space;
    assign accept = pixel_valid_i && !stall_o;

    always_ff @(posedge clk_pll) begin
        if (accept) begin
            pixel_q <= pixel_i;
        end
    end

    // byte_idx is zero whenever the fsm sits in IDLE
    assign header_byte = MAGIC_NUM[8*(HEADER_BYTES-1-byte_idx) +: 8];

    always_comb begin
        emit = 1'b0;
        next_byte = pixel_q.ch1;
        case (state)
            IDLE: begin
                emit = accept;
                next_byte = sof_i ? header_byte : pixel_i.ch0;
            end
            HEADER: begin
                emit = has_space;
                next_byte = header_byte;
            end
            CH0: begin
                emit = has_space;
                next_byte = pixel_q.ch0;
            end
            default: begin
                emit = has_space;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            state            <= IDLE;
            byte_idx         <= '0;
            out_byte_valid_o <= 1'b0;
        end else begin
            out_byte_valid_o <= emit;
            if (emit) begin
                case (state)
                    IDLE: begin
                        if (sof_i) begin
                            byte_idx <= HDR_IDX_BITS'(1);
                            state    <= HEADER;
                        end else begin
                            state <= CH1;
                        end
                    end
                    HEADER: begin
                        if (byte_idx == HDR_IDX_BITS'(HEADER_BYTES - 1)) begin
                            byte_idx <= '0;
                            state    <= CH0;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                    CH0: state <= CH1;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_pll) begin
        if (emit) begin
            out_byte_o <= next_byte;
        end
    end

endmodule

`default_nettype wire

/* host_link/constants_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module constants_controller (
    input  wire logic                    clk_pll,
    input  wire logic                    sys_reset,
    input  wire previewer_pkg::command_t cmd_i,
    input  wire logic                    cmd_valid_i,
    output previewer_pkg::matrix_set_t   matrices_o,
    output previewer_pkg::roi_corner_t   pre_roi_o,
    output previewer_pkg::roi_corner_t   post_roi_o,
    output logic                         shutter_en_o
);
    import previewer_pkg::*;

    cmd_data_u data_view;

    assign data_view = cmd_i.data;

    ////////////////////////////////////////////////////////////////////////////
    // bilinear matrices
    // coefficient k of camera c lives at base + 9c + k
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            for (int c = 0; c < NUM_CAMERAS; c++) begin
                for (int k = 0; k < MATRIX_COEFFS; k++) begin
                    // identity, diagonal is 1.0 in fixed point
                    if (k / 3 == k % 3) begin
                        matrices_o[c][k] <= coeff_t'(1 << PRECISION);
                    end else begin
                        matrices_o[c][k] <= '0;
                    end
                end
            end
        end else if (cmd_valid_i) begin
            for (int c = 0; c < NUM_CAMERAS; c++) begin
                for (int k = 0; k < MATRIX_COEFFS; k++) begin
                    if (cmd_i.addr == 16'(ADDR_MATRIX_BASE + MATRIX_COEFFS * c + k)) begin
                        matrices_o[c][k] <= data_view.coeff.coeff;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // roi corners and shutter enable
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            pre_roi_o.row  <= '0;
            pre_roi_o.col  <= 16'(DEFAULT_PRE_ROI_COL);
            post_roi_o.row <= '0;
            post_roi_o.col <= 16'(DEFAULT_POST_ROI_COL);
            shutter_en_o   <= 1'b0;
        end else if (cmd_valid_i) begin
            // unmapped addresses fall through untouched
            case (cmd_i.addr)
                ADDR_PRE_ROI: begin
                    pre_roi_o <= data_view.roi;
                end
                ADDR_POST_ROI: begin
                    post_roi_o <= data_view.roi;
                end
                ADDR_SHUTTER_EN: begin
                    shutter_en_o <= cmd_i.data[0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* host_link/word_concatenator.sv */
`timescale 1ns/1ns
`default_nettype none

module word_concatenator (
    input  wire logic               clk_pll,
    input  wire logic               sys_reset,
    input  wire logic [7:0]         byte_i,
    input  wire logic               byte_valid_i,
    output previewer_pkg::command_t cmd_o,
    output logic                    cmd_valid_o
);
    import previewer_pkg::*;

    logic [8*CMD_BYTES-1:0]  acc_q;
    logic [CMD_CNT_BITS-1:0] byte_cnt;

    // first byte ends up in the top of the word
    always_ff @(posedge clk_pll) begin
        if (byte_valid_i) begin
            acc_q <= {acc_q[8*CMD_BYTES-9:0], byte_i};
        end
    end

    // byte count modulo CMD_BYTES
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            byte_cnt    <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (byte_valid_i) begin
                if (byte_cnt == CMD_CNT_BITS'(CMD_BYTES - 1)) begin
                    byte_cnt    <= '0;
                    cmd_valid_o <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // only meaningful while cmd_valid_o is high
    assign cmd_o = acc_q;

endmodule

`default_nettype wire

/* common/previewer_pkg.sv */
`default_nettype none

package previewer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // image and matrix geometry
    localparam int PRECISION = 8;
    localparam int COEFF_WIDTH = 11 + PRECISION;
    localparam int NUM_CAMERAS = 2;
    localparam int MATRIX_COEFFS = 9;

    localparam int RAW_IMAGE_WIDTH = 640;
    localparam int IMAGE_WIDTH = 512;
    localparam int ROI_WIDTH = 400;
    localparam int DEFAULT_PRE_ROI_COL = (RAW_IMAGE_WIDTH - IMAGE_WIDTH) / 2;
    localparam int DEFAULT_POST_ROI_COL = (IMAGE_WIDTH - ROI_WIDTH) / 2;

    ////////////////////////////////////////////////////////////////////////////
    // output framing and camera timing
    // ascii "BIVFRAME", sent most significant byte first
    localparam logic [63:0] MAGIC_NUM = 64'h4249_5646_5241_4d45;
    localparam int HEADER_BYTES = 8;
    localparam int HDR_IDX_BITS = $clog2(HEADER_BYTES);
    localparam int SPACE_THRESHOLD = 32;

    localparam int SHUTTER_PERIOD = 1024;
    localparam int SHUTTER_CNT_BITS = $clog2(SHUTTER_PERIOD);
    localparam int MCLK_DIV_BITS = 2;

    ////////////////////////////////////////////////////////////////////////////
    // host command map
    localparam int CMD_BYTES = 6;
    localparam int CMD_CNT_BITS = $clog2(CMD_BYTES);
    localparam logic [15:0] ADDR_MATRIX_BASE = 16'h0000;
    localparam logic [15:0] ADDR_PRE_ROI = 16'h0100;
    localparam logic [15:0] ADDR_POST_ROI = 16'h0101;
    localparam logic [15:0] ADDR_SHUTTER_EN = 16'h0200;

    typedef logic signed [COEFF_WIDTH-1:0] coeff_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } command_t;

    typedef struct packed {
        logic [15:0] row;
        logic [15:0] col;
    } roi_corner_t;

    // coefficient sits in the low bits of the data word
    typedef struct packed {
        logic [31-COEFF_WIDTH:0] pad;
        coeff_t                  coeff;
    } coeff_word_t;

    typedef union packed {
        roi_corner_t roi;
        coeff_word_t coeff;
    } cmd_data_u;

    // [camera][coefficient], row-major 3x3
    typedef coeff_t [NUM_CAMERAS-1:0][MATRIX_COEFFS-1:0] matrix_set_t;

    typedef struct packed {
        logic [7:0] ch0;
        logic [7:0] ch1;
    } pixel_pair_t;

endpackage

`default_nettype wire
